// File: flist.f
+incdir+hdl
hdl/qq_key_pkg.sv
hdl/qq_ctl_pkg.sv
hdl/qq_link_if.sv
hdl/qq_fsm.sv
hdl/qq_cell.sv
hdl/qq_top.sv
verif/tb_clk_gen.sv
verif/tb_qq.sv

// File: run_sim.sh
#!/bin/sh
# build and run the priority queue testbench, fail on the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_qq \
    && ./obj_dir/Vtb_qq > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0

// File: verif/tb_qq.sv
`timescale 1ns/10ps
`include "qq_params.svh"

module tb_qq;

    localparam int CAP      = `QQ_DEPTH * `QQ_CELLS;
    localparam int OP_LIMIT = 200;      // cycles allowed per operation
    localparam int N_MIXED  = 300;      // transfers in the mixed test
    localparam int CLK_NS   = 20;
    // sort + capacity + mixed with drain + edge keys
    localparam int N_OPS    = 24 + 2 * CAP + 2 + N_MIXED + CAP + 20;

    logic              clk;
    logic              rst;
    logic              enq_valid_i;
    qq_key_pkg::key_t  enq_key_i;
    logic              enq_ready_o;
    logic              deq_valid_o;
    qq_key_pkg::key_t  deq_key_o;
    logic              deq_ready_i;

    int                model_q [$];  // reference contents, unordered
    int                model_cnt;
    qq_key_pkg::key_t  exp_min;      // expected head at the coming edge
    qq_key_pkg::key_t  got_q [$];    // keys taken at dequeue transfers
    logic [31:0]       rnd_state;
    bit                enq_done;     // transfers of the last cycle
    bit                deq_done;
    int                err_cnt;
    int                test_cnt;
    logic              c0_idle;
    logic              deq_fire;

    tb_clk_gen #(.PERIOD(CLK_NS), .RST_CYCLES(5)) u_clk_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    qq_top u_qq_top (
        .clk         (clk),
        .rst         (rst),
        .enq_valid_i (enq_valid_i),
        .enq_key_i   (enq_key_i),
        .enq_ready_o (enq_ready_o),
        .deq_valid_o (deq_valid_o),
        .deq_key_o   (deq_key_o),
        .deq_ready_i (deq_ready_i)
    );

    assign c0_idle  = u_qq_top.c_rdy[0];  // cell 0 waiting for a command
    assign deq_fire = deq_valid_o && deq_ready_i && !(enq_valid_i && enq_ready_o);

    // ------------------------------------------------------------------
    // protocol checks
    // ------------------------------------------------------------------

    a_rst_quiet: assert property (@(posedge clk) rst |-> (!enq_ready_o && !deq_valid_o))
        else begin
            $display("Mismatch at %0t: handshake outputs active in reset", $time);
            err_cnt++;
        end

    a_head: assert property (@(posedge clk) disable iff (rst) deq_fire |-> deq_key_o == exp_min)
        else begin
            $display("Mismatch at %0t: dequeued %h, expected %h", $time, deq_key_o, exp_min);
            err_cnt++;
        end

    a_valid: assert property (@(posedge clk) disable iff (rst)
            c0_idle |-> deq_valid_o == (model_cnt != 0))
        else begin
            $display("Mismatch at %0t: deq_valid_o %b with %0d keys held",
                     $time, deq_valid_o, model_cnt);
            err_cnt++;
        end

    a_full: assert property (@(posedge clk) disable iff (rst)
            c0_idle |-> !enq_ready_o == (model_cnt == CAP))
        else begin
            $display("Mismatch at %0t: enq_ready_o %b with %0d keys held",
                     $time, enq_ready_o, model_cnt);
            err_cnt++;
        end

    // ------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        rnd_state = xorshift32(rnd_state);
        return rnd_state;
    endfunction

    function automatic qq_key_pkg::key_t rand_key();
        logic [31:0]      w;
        qq_key_pkg::key_t k;
        w = rand_word();
        k = w[`QQ_KEY_W-1:0];
        if (k == qq_key_pkg::MAX_KEY) begin
            k = k - 1'b1;  // all ones is reserved
        end
        return k;
    endfunction

    function automatic int model_min();
        int m;
        m = int'(qq_key_pkg::MAX_KEY);  // empty model shows the marker
        foreach (model_q[i]) begin
            if (model_q[i] < m) begin
                m = model_q[i];
            end
        end
        return m;
    endfunction

    // one clock, negedge to negedge, with the model following the transfers
    task automatic run_cycle();
        bit               enq_go;
        bit               deq_go;
        qq_key_pkg::key_t head;
        int               idx;
        enq_go  = enq_valid_i && enq_ready_o;
        deq_go  = deq_valid_o && deq_ready_i && !enq_go;  // enqueue wins
        head    = deq_key_o;
        exp_min = qq_key_pkg::key_t'(model_min());
        @(negedge clk);
        enq_done = enq_go;
        deq_done = deq_go;
        if (enq_go) begin
            model_q.push_back(int'(enq_key_i));
        end
        if (deq_go && model_q.size() > 0) begin
            got_q.push_back(head);
            idx = 0;
            foreach (model_q[i]) begin
                if (model_q[i] < model_q[idx]) begin
                    idx = i;
                end
            end
            model_q.delete(idx);
        end
        model_cnt = model_q.size();
    endtask

    task automatic push(input qq_key_pkg::key_t key);
        int n;
        n           = 0;
        enq_valid_i = 1'b1;
        enq_key_i   = key;
        do begin
            run_cycle();
            n++;
        end while (!enq_done && n < OP_LIMIT);
        enq_valid_i = 1'b0;
        if (!enq_done) begin
            $display("enqueue of key %h not accepted within %0d cycles", key, OP_LIMIT);
            err_cnt++;
        end
    endtask

    task automatic pop();
        int n;
        n           = 0;
        deq_ready_i = 1'b1;
        do begin
            run_cycle();
            n++;
        end while (!deq_done && n < OP_LIMIT);
        deq_ready_i = 1'b0;
        if (!deq_done) begin
            $display("no dequeue within %0d cycles", OP_LIMIT);
            err_cnt++;
        end
    endtask

    task automatic drain();
        int n;
        n           = 0;
        deq_ready_i = 1'b1;
        while (model_cnt > 0 && n < CAP * OP_LIMIT) begin
            run_cycle();
            n++;
        end
        deq_ready_i = 1'b0;
        if (model_cnt > 0) begin
            $display("queue did not drain, %0d keys still expected", model_cnt);
            err_cnt++;
        end
    endtask

    task automatic check_sorted(input int expect_n);
        assert (got_q.size() == expect_n)
            else begin
                $display("Mismatch at %0t: %0d keys returned, expected %0d",
                         $time, got_q.size(), expect_n);
                err_cnt++;
            end
        for (int i = 1; i < got_q.size(); i++) begin
            assert (got_q[i] >= got_q[i-1])
                else begin
                    $display("Mismatch at %0t: %h came out after %h", $time, got_q[i], got_q[i-1]);
                    err_cnt++;
                end
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_cnt++;
        $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
    endtask

    // ------------------------------------------------------------------
    // watchdog
    // ------------------------------------------------------------------

    initial begin
        #(N_OPS * OP_LIMIT * CLK_NS);
        $display("watchdog expired at %0t, the tests did not finish", $time);
        $display("Testbench failed");
        $finish;
    end

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------

    initial begin
        int                n;
        int                n_xfer;
        int                e0;
        logic [31:0]       w;
        qq_key_pkg::key_t  held;
        qq_key_pkg::key_t  top_key;
        qq_key_pkg::key_t  edge_keys [10];
        enq_valid_i = 1'b0;
        enq_key_i   = '0;
        deq_ready_i = 1'b0;
        rnd_state   = 32'hffa4;  // fixed seed
        model_cnt   = 0;
        exp_min     = qq_key_pkg::MAX_KEY;
        enq_done    = 1'b0;
        deq_done    = 1'b0;
        err_cnt     = 0;
        test_cnt    = 0;

        // reset and slot fill
        e0 = err_cnt;
        @(negedge rst);
        n = 0;
        do begin
            @(negedge clk);
            n++;
            assert (!deq_valid_o)
                else begin
                    $display("Mismatch at %0t: deq_valid_o high on an empty queue", $time);
                    err_cnt++;
                end
        end while (!enq_ready_o && n < OP_LIMIT);
        assert (n == `QQ_DEPTH + 1)
            else begin
                $display("Mismatch at %0t: enq_ready_o rose after %0d cycles, expected %0d",
                         $time, n, `QQ_DEPTH + 1);
                err_cnt++;
            end
        end_test("reset", e0);

        // sort
        e0 = err_cnt;
        got_q.delete();
        repeat (12) push(rand_key());
        drain();
        check_sorted(12);
        end_test("sort", e0);

        // capacity
        e0 = err_cnt;
        repeat (CAP) push(rand_key());
        held        = rand_key();
        enq_valid_i = 1'b1;   // held against a full queue
        enq_key_i   = held;
        repeat (20) begin
            run_cycle();
            assert (!enq_done)
                else begin
                    $display("Mismatch at %0t: enqueue accepted into a full queue", $time);
                    err_cnt++;
                end
        end
        pop();                // enq_valid_i still high here
        push(held);
        got_q.delete();
        drain();
        check_sorted(CAP);
        end_test("capacity", e0);

        // mixed traffic with back-pressure
        e0     = err_cnt;
        n      = 0;
        n_xfer = 0;
        while (n_xfer < N_MIXED && n < N_MIXED * OP_LIMIT) begin
            w = rand_word();
            if (!enq_valid_i && w[0]) begin
                enq_valid_i = 1'b1;
                enq_key_i   = rand_key();
            end
            deq_ready_i = w[7];
            run_cycle();
            if (enq_done) begin
                enq_valid_i = 1'b0;
            end
            n_xfer = n_xfer + int'(enq_done) + int'(deq_done);
            n++;
        end
        enq_valid_i = 1'b0;
        deq_ready_i = 1'b0;
        if (n_xfer < N_MIXED) begin
            $display("mixed traffic stalled after %0d transfers", n_xfer);
            err_cnt++;
        end
        drain();
        end_test("mixed", e0);

        // duplicates and the extreme keys
        e0        = err_cnt;
        top_key   = qq_key_pkg::MAX_KEY - 1'b1;
        edge_keys = '{16'd5, 16'd0, top_key, 16'd5, 16'd0, top_key, 16'd7, 16'd5, 16'd0, 16'd7};
        got_q.delete();
        foreach (edge_keys[i]) begin
            push(edge_keys[i]);
        end
        drain();
        check_sorted(10);
        end_test("edge keys", e0);

        $display("tests run %0d, failed checks %0d", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: verif/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int PERIOD     = 20,  // ns
    parameter int RST_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // reset seen by RST_CYCLES rising edges, released on a falling edge
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

// File: hdl/qq_top.sv
`timescale 1ns/10ps
`include "qq_params.svh"

module qq_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              enq_valid_i,
    input  qq_key_pkg::key_t  enq_key_i,
    output logic              enq_ready_o,
    output logic              deq_valid_o,
    output qq_key_pkg::key_t  deq_key_o,
    input  logic              deq_ready_i
);

    localparam int CELLS = `QQ_CELLS;
    localparam int CAP   = `QQ_DEPTH * `QQ_CELLS;
    localparam int CW    = $clog2(CAP + 1);

    // per cell command side, index k is the input of cell k
    logic              c_enq   [CELLS];
    logic              c_deq   [CELLS];
    qq_key_pkg::key_t  c_key   [CELLS];
    logic              c_rdy   [CELLS];
    logic              c_empty [CELLS];
    qq_key_pkg::key_t  c_head  [CELLS];

    logic              enq_fire;
    logic              deq_fire;
    logic [CW-1:0]     q_cnt;     // keys held, including ones still rippling

    // ------------------------------------------------------------------
    // handshakes on cell 0
    // ------------------------------------------------------------------

    assign enq_ready_o = c_rdy[0] && (q_cnt != CW'(CAP));
    assign deq_valid_o = c_rdy[0] && !c_empty[0];
    assign enq_fire    = enq_valid_i && enq_ready_o;
    assign deq_fire    = deq_valid_o && deq_ready_i && !enq_fire;  // enqueue wins
    assign deq_key_o   = c_head[0];

    assign c_enq[0] = enq_fire;
    assign c_deq[0] = deq_fire;
    assign c_key[0] = enq_key_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            q_cnt <= '0;
        end else if (enq_fire) begin
            q_cnt <= q_cnt + 1'b1;
        end else if (deq_fire) begin
            q_cnt <= q_cnt - 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // cell chain
    // ------------------------------------------------------------------

    for (genvar k = 0; k < CELLS; k++) begin : g_cell
        qq_link_if u_link ();

        qq_cell u_cell (
            .clk     (clk),
            .rst     (rst),
            .enq_i   (c_enq[k]),
            .deq_i   (c_deq[k]),
            .key_i   (c_key[k]),
            .rdy_o   (c_rdy[k]),
            .full_o  (),
            .empty_o (c_empty[k]),
            .head_o  (c_head[k]),
            .link    (u_link)
        );

        if (k < CELLS - 1) begin : g_mid
            assign c_enq[k+1]  = u_link.enq;
            assign c_deq[k+1]  = u_link.deq;
            assign c_key[k+1]  = u_link.data_lt;
            assign u_link.head = c_head[k+1];
            assign u_link.rdy  = c_rdy[k+1];
        end else begin : g_end
            // nothing beyond the last cell, pushes fall off here
            assign u_link.head = qq_key_pkg::MAX_KEY;
            assign u_link.rdy  = 1'b1;
        end
    end

endmodule

// File: hdl/qq_cell.sv
`timescale 1ns/10ps
`include "qq_params.svh"

module qq_cell (
    input  logic              clk,
    input  logic              rst,
    input  logic              enq_i,    // from left neighbour or top
    input  logic              deq_i,
    input  qq_key_pkg::key_t  key_i,
    output logic              rdy_o,
    output logic              full_o,
    output logic              empty_o,
    output qq_key_pkg::key_t  head_o,   // smallest key of the cell
    qq_link_if.left           link      // to right neighbour
);

    localparam int DEPTH = `QQ_DEPTH;

    qq_key_pkg::key_t   ram [DEPTH];  // sorted slots, ascending
    qq_key_pkg::key_t   temp_q;       // key in flight
    qq_key_pkg::key_t   ram_out;
    qq_key_pkg::key_t   wr_data;
    qq_key_pkg::addr_t  wr_addr_q;
    qq_key_pkg::addr_t  rd_addr;
    qq_key_pkg::addr_t  rd_ofs;
    logic               full_q;
    logic               empty_q;
    logic               t_gt_ram;

    // strobes from the FSM
    logic               sel_t;
    logic               ld_t;
    logic               clr_wraddr;
    logic               incr_wraddr;
    logic               we;
    logic               set_full;
    logic               clr_full;
    logic               set_empty;
    logic               clr_empty;
    qq_ctl_pkg::rofs_t  rofs;
    qq_ctl_pkg::wsel_t  wsel;

    // ------------------------------------------------------------------
    // slot storage and read ports
    // ------------------------------------------------------------------

    always_comb begin
        case (rofs)
            qq_ctl_pkg::OFS_1: rd_ofs = qq_key_pkg::addr_t'(1);
            qq_ctl_pkg::OFS_2: rd_ofs = qq_key_pkg::addr_t'(2);
            default:           rd_ofs = '0;
        endcase
    end

    assign rd_addr = wr_addr_q + rd_ofs;  // wraps within the cell
    assign ram_out = ram[rd_addr];
    assign head_o  = ram[0];

    always_comb begin
        case (wsel)
            qq_ctl_pkg::W_RAM:   wr_data = ram_out;    // shift up
            qq_ctl_pkg::W_TEMP:  wr_data = temp_q;
            qq_ctl_pkg::W_RIGHT: wr_data = link.head;
            default:             wr_data = qq_key_pkg::MAX_KEY;
        endcase
    end

    always_ff @(posedge clk) begin
        if (we) begin
            ram[wr_addr_q] <= wr_data;
        end
    end

    // ------------------------------------------------------------------
    // temp register and comparator
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (ld_t) begin
            temp_q <= sel_t ? ram_out : key_i;  // displaced key or new key
        end
    end

    assign t_gt_ram     = (temp_q > ram_out);
    assign link.data_lt = temp_q;                // overflow key goes right

    // ------------------------------------------------------------------
    // flag and address registers
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_addr_q <= '0;
            full_q    <= 1'b0;
            empty_q   <= 1'b1;
        end else begin
            if (clr_wraddr) begin
                wr_addr_q <= '0;
            end else if (incr_wraddr) begin
                wr_addr_q <= wr_addr_q + qq_key_pkg::addr_t'(1);
            end
            if (set_full) begin
                full_q <= 1'b1;  // last slot holds a key
            end else if (clr_full) begin
                full_q <= 1'b0;
            end
            if (set_empty) begin
                empty_q <= 1'b1; // slot 0 is MAX_KEY
            end else if (clr_empty) begin
                empty_q <= 1'b0;
            end
        end
    end

    assign full_o  = full_q;
    assign empty_o = empty_q;

    // ------------------------------------------------------------------
    // controller
    // ------------------------------------------------------------------

    qq_fsm u_fsm (
        .clk           (clk),
        .rst           (rst),
        .enq_i         (enq_i),
        .deq_i         (deq_i),
        .t_gt_ram_i    (t_gt_ram),
        .full_i        (full_q),
        .ram_out_i     (ram_out),
        .wr_addr_i     (wr_addr_q),
        .rd_addr_i     (rd_addr),
        .rt_rdy_i      (link.rdy),
        .rdy_o         (rdy_o),
        .sel_t_o       (sel_t),
        .ld_t_o        (ld_t),
        .clr_wraddr_o  (clr_wraddr),
        .incr_wraddr_o (incr_wraddr),
        .we_o          (we),
        .enq_o         (link.enq),
        .deq_o         (link.deq),
        .set_full_o    (set_full),
        .clr_full_o    (clr_full),
        .set_empty_o   (set_empty),
        .clr_empty_o   (clr_empty),
        .rofs_o        (rofs),
        .wsel_o        (wsel)
    );

endmodule

// File: hdl/qq_fsm.sv
`timescale 1ns/10ps
`include "qq_params.svh"

module qq_fsm (
    input  logic               clk,
    input  logic               rst,
    input  logic               enq_i,          // command from left
    input  logic               deq_i,
    input  logic               t_gt_ram_i,     // temp > slot read
    input  logic               full_i,
    input  qq_key_pkg::key_t   ram_out_i,
    input  qq_key_pkg::addr_t  wr_addr_i,
    input  qq_key_pkg::addr_t  rd_addr_i,
    input  logic               rt_rdy_i,       // right neighbour idle
    output logic               rdy_o,
    output logic               sel_t_o,        // 0 key_i, 1 slot read
    output logic               ld_t_o,
    output logic               clr_wraddr_o,
    output logic               incr_wraddr_o,
    output logic               we_o,
    output logic               enq_o,          // push to right
    output logic               deq_o,          // pop of right
    output logic               set_full_o,
    output logic               clr_full_o,
    output logic               set_empty_o,
    output logic               clr_empty_o,
    output qq_ctl_pkg::rofs_t  rofs_o,
    output qq_ctl_pkg::wsel_t  wsel_o
);

    localparam qq_key_pkg::addr_t LAST = qq_key_pkg::addr_t'(`QQ_DEPTH - 1);

    qq_ctl_pkg::state_t state_q;
    qq_ctl_pkg::state_t state_d;
    logic               at_max;  // slot on read port is empty

    assign at_max = (ram_out_i == qq_key_pkg::MAX_KEY);

    // ------------------------------------------------------------------
    // state register
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= qq_ctl_pkg::INIT1;
        end else begin
            state_q <= state_d;
        end
    end

    // ------------------------------------------------------------------
    // next state and strobes
    // ------------------------------------------------------------------

    always_comb begin
        state_d       = state_q;
        rdy_o         = 1'b0;
        sel_t_o       = 1'b0;
        ld_t_o        = 1'b0;
        clr_wraddr_o  = 1'b0;
        incr_wraddr_o = 1'b0;
        we_o          = 1'b0;
        enq_o         = 1'b0;
        deq_o         = 1'b0;
        set_full_o    = 1'b0;
        clr_full_o    = 1'b0;
        set_empty_o   = 1'b0;
        clr_empty_o   = 1'b0;
        rofs_o        = qq_ctl_pkg::OFS_0;  // read the write slot
        wsel_o        = qq_ctl_pkg::W_RAM;

        case (state_q)
            qq_ctl_pkg::INIT1: begin
                clr_wraddr_o = 1'b1;
                set_empty_o  = 1'b1;
                clr_full_o   = 1'b1;
                state_d      = qq_ctl_pkg::INIT2;
            end

            // one slot per cycle gets the empty marker
            qq_ctl_pkg::INIT2: begin
                wsel_o = qq_ctl_pkg::W_MAX;
                we_o   = 1'b1;
                if (wr_addr_i == LAST) begin
                    clr_wraddr_o = 1'b1;
                    state_d      = qq_ctl_pkg::IDLE;
                end else begin
                    incr_wraddr_o = 1'b1;
                end
            end

            qq_ctl_pkg::IDLE: begin
                rdy_o        = 1'b1;
                clr_wraddr_o = 1'b1;  // every walk starts at slot 0
                // address left at last slot by a pull, full follows that slot
                if (wr_addr_i == LAST) begin
                    if (full_i && at_max) begin
                        clr_full_o = 1'b1;
                    end
                    if (!full_i && !at_max) begin
                        set_full_o = 1'b1;
                    end
                end
                if (enq_i) begin
                    sel_t_o = 1'b0;  // temp <= key_i
                    ld_t_o  = 1'b1;
                    state_d = qq_ctl_pkg::ENQ1;
                end else if (deq_i) begin
                    state_d = qq_ctl_pkg::DEQ1;
                end
            end

            // temp sinks until it meets a larger key, swapping as it goes
            qq_ctl_pkg::ENQ1: begin
                clr_empty_o = 1'b1;
                if (!t_gt_ram_i) begin
                    wsel_o  = qq_ctl_pkg::W_TEMP;  // slot <= temp
                    we_o    = 1'b1;
                    sel_t_o = 1'b1;                // temp <= old slot
                    ld_t_o  = 1'b1;
                end
                if (at_max) begin
                    // key landed in a free slot
                    clr_wraddr_o = 1'b1;
                    if (wr_addr_i == LAST) begin
                        set_full_o = 1'b1;
                    end
                    state_d = qq_ctl_pkg::IDLE;
                end else if (wr_addr_i == LAST) begin
                    state_d = qq_ctl_pkg::ENQRT;   // temp overflows right
                end else begin
                    incr_wraddr_o = 1'b1;
                end
            end

            qq_ctl_pkg::ENQRT: begin
                if (rt_rdy_i) begin
                    enq_o        = 1'b1;  // data_lt is temp
                    clr_wraddr_o = 1'b1;
                    state_d      = qq_ctl_pkg::IDLE;
                end
            end

            // slot i <= slot i+1
            qq_ctl_pkg::DEQ1: begin
                rofs_o = qq_ctl_pkg::OFS_1;
                wsel_o = qq_ctl_pkg::W_RAM;
                we_o   = 1'b1;
                if (at_max) begin
                    clr_wraddr_o = 1'b1;
                    if (wr_addr_i == '0) begin
                        set_empty_o = 1'b1;  // only key just left
                    end
                    state_d = qq_ctl_pkg::IDLE;
                end else begin
                    incr_wraddr_o = 1'b1;
                    if (rd_addr_i == LAST) begin
                        state_d = qq_ctl_pkg::DEQRT;
                    end
                end
            end

            // last slot <= right head, right pops next cycle
            qq_ctl_pkg::DEQRT: begin
                wsel_o = qq_ctl_pkg::W_RIGHT;
                if (rt_rdy_i) begin
                    we_o    = 1'b1;
                    deq_o   = 1'b1;
                    state_d = qq_ctl_pkg::IDLE;  // keeps address for full check
                end
            end

            default: begin
                state_d = qq_ctl_pkg::INIT1;
            end
        endcase
    end

endmodule

// File: hdl/qq_link_if.sv
`timescale 1ns/10ps

// link between cell k (left) and cell k+1 (right)
interface qq_link_if;

    logic             enq;      // one cycle push of data_lt
    logic             deq;      // one cycle pop of right cell
    qq_key_pkg::key_t data_lt;  // key pushed right
    qq_key_pkg::key_t head;     // slot 0 of right cell
    logic             rdy;      // right cell idle

    // left cell drives the commands
    modport left (
        output enq,
        output deq,
        output data_lt,
        input  head,
        input  rdy
    );

    // right cell answers with head and ready
    modport right (
        input  enq,
        input  deq,
        input  data_lt,
        output head,
        output rdy
    );

endinterface

// File: hdl/qq_ctl_pkg.sv
// controller encodings of a queue cell
package qq_ctl_pkg;

    // ------------------------------------------------------------------
    // cell FSM states
    // ------------------------------------------------------------------

    typedef enum logic [2:0] {
        INIT1 = 3'd0,  // clear address, flag cell empty
        INIT2 = 3'd1,  // fill slots with MAX_KEY
        IDLE  = 3'd2,  // ready for a command
        ENQ1  = 3'd3,  // insertion walk
        ENQRT = 3'd4,  // push displaced key right
        DEQ1  = 3'd5,  // shift walk
        DEQRT = 3'd6   // pull head of right cell
    } state_t;

    // ------------------------------------------------------------------
    // datapath steering
    // ------------------------------------------------------------------

    // write data of the slot registers
    typedef enum logic [1:0] {
        W_RAM   = 2'd0,  // slot read port, for the shift
        W_TEMP  = 2'd1,  // temp register
        W_RIGHT = 2'd2,  // head of right neighbour
        W_MAX   = 2'd3   // empty marker
    } wsel_t;

    // read address = write address + offset
    typedef enum logic [1:0] {
        OFS_0 = 2'd0,
        OFS_1 = 2'd1,
        OFS_2 = 2'd2
    } rofs_t;

endpackage

// File: hdl/qq_key_pkg.sv
`include "qq_params.svh"

// key and slot types shared by the cells, the links and the top
package qq_key_pkg;

    // ------------------------------------------------------------------
    // key
    // ------------------------------------------------------------------

    typedef logic [`QQ_KEY_W-1:0] key_t;

    // all ones marks an empty slot, never enqueued
    localparam key_t MAX_KEY = '1;

    // ------------------------------------------------------------------
    // slot index inside one cell
    // ------------------------------------------------------------------

    typedef logic [$clog2(`QQ_DEPTH)-1:0] addr_t;

endpackage

// File: hdl/qq_params.svh
`ifndef QQ_PARAMS_SVH
`define QQ_PARAMS_SVH

// ----------------------------------------------------------------------
// queue sizing
// ----------------------------------------------------------------------

// key width in bits
`define QQ_KEY_W 16

// slots per cell, power of two, 4 or more
`define QQ_DEPTH 4

// cells in the chain
`define QQ_CELLS 4

// capacity is QQ_DEPTH * QQ_CELLS keys

`endif
